/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f mul_unit.f --top-module mul_unit_tb

sim:
	verilator --binary --timing --assert -f mul_unit.f --top-module mul_unit_tb -o mul_unit_sim
	@out=$$(./obj_dir/mul_unit_sim); echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

/* hw/booth_encoder.sv */
`include "mul_cfg.svh"

module booth_encoder (
	input  logic [2:0]            digit,
	input  logic [`MUL_EXT_W-1:0] multiplicand,
	output logic [`MUL_EXT_W+1:0] pp
);

	mul_pkg::booth_op_e op;
	logic [`MUL_EXT_W+1:0] mc_ext;
	logic [`MUL_EXT_W+1:0] mc_dbl;

	// ****************************************
	// triplet decode
	// ****************************************

	// digit is {y[2i+1], y[2i], y[2i-1]}
	always_comb begin
		case (digit)
			3'b000, 3'b111: op = mul_pkg::ZERO;
			3'b001, 3'b010: op = mul_pkg::ADD1;
			3'b011:         op = mul_pkg::ADD2;
			3'b100:         op = mul_pkg::SUB2;
			3'b101, 3'b110: op = mul_pkg::SUB1;
			default:        op = mul_pkg::ZERO;
		endcase
	end

	// ****************************************
	// partial product select
	// ****************************************

	// widen before doubling so 2x and the negation do not overflow
	assign mc_ext = {{2{multiplicand[`MUL_EXT_W-1]}}, multiplicand};
	assign mc_dbl = {mc_ext[`MUL_EXT_W:0], 1'b0};

	always_comb begin
		case (op)
			mul_pkg::ADD1: pp = mc_ext;
			mul_pkg::ADD2: pp = mc_dbl;
			mul_pkg::SUB1: pp = ~mc_ext + 1'b1;
			mul_pkg::SUB2: pp = ~mc_dbl + 1'b1;
			default:       pp = '0;
		endcase
	end

	// decoder must only emit the five booth selections
	always_comb begin
		a_op_legal: assert (op inside {mul_pkg::ZERO, mul_pkg::ADD1, mul_pkg::ADD2,
			mul_pkg::SUB1, mul_pkg::SUB2});
	end

endmodule

/* hw/mul_accumulator.sv */
`include "mul_cfg.svh"

module mul_accumulator (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  logic                  step,
	input  mul_pkg::mul_ext_t     ext,
	input  logic [`MUL_EXT_W+1:0] pp,
	output logic [2:0]            digit,
	output logic [`MUL_EXT_W-1:0] multiplicand,
	output mul_pkg::mul_rsp_t     rsp
);

	// partial sum field, same width as a partial product
	localparam int sum_w = `MUL_EXT_W + 2;
	// {partial sum, multiplier, guard}
	localparam int acc_w = sum_w + `MUL_EXT_W + 1;
	localparam int low_w = `MUL_EXT_W + 1;
	localparam int prod_w = 2 * `MUL_XLEN;
	localparam int half_w = `MUL_XLEN / 2;

	logic [`MUL_EXT_W-1:0] mcand_q;
	logic [acc_w-1:0] acc_q;
	logic mulw_q;
	logic [sum_w-1:0] sum_add;
	logic [prod_w-1:0] prod;
	logic word_sign;

	// ****************************************
	// booth window
	// ****************************************

	// low two multiplier bits plus the guard bit
	assign digit        = acc_q[2:0];
	assign multiplicand = mcand_q;

	// add the partial product into the upper field
	assign sum_add = acc_q[acc_w-1:low_w] + pp;

	// ****************************************
	// registers
	// ****************************************

	// multiplicand is only ever sampled on load
	always_ff @(posedge clk) begin
		if (load)
			mcand_q <= ext.multiplicand;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			acc_q  <= '0;
			mulw_q <= 1'b0;
		end else if (load) begin
			// sum cleared, multiplier in place, guard zero
			acc_q  <= {{sum_w{1'b0}}, ext.multiplier, 1'b0};
			mulw_q <= ext.mulw;
		end else if (step) begin
			// arithmetic shift by one radix-4 digit
			acc_q <= {{2{sum_add[sum_w-1]}}, sum_add, acc_q[low_w-1:2]};
		end
	end

	// ****************************************
	// result formatting
	// ****************************************

	// after all steps product bit 0 sits just above the guard
	assign prod      = acc_q[prod_w:1];
	assign word_sign = prod[half_w-1];

	always_comb begin
		if (mulw_q) begin
			// mulw keeps the low word, sign extended everywhere
			rsp.result_lo = {{half_w{word_sign}}, prod[half_w-1:0]};
			rsp.result_hi = {`MUL_XLEN{word_sign}};
		end else begin
			rsp.result_lo = prod[`MUL_XLEN-1:0];
			rsp.result_hi = prod[prod_w-1:`MUL_XLEN];
		end
	end

endmodule

/* hw/mul_ctrl.sv */
`include "mul_cfg.svh"

module mul_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic mul_valid,
	input  logic flush,
	output logic mul_ready,
	output logic load,
	output logic step,
	output logic out_valid
);

	// count value seen on the final step edge
	localparam int unsigned last_step = `MUL_STEPS - 1;

	mul_pkg::mul_state_e state;
	logic [`MUL_CNT_W-1:0] cnt;

	// ****************************************
	// strobes
	// ****************************************

	// idle level doubles as ready
	assign mul_ready = (state == mul_pkg::IDLE);
	// flush wins over a start in the same cycle
	assign load = mul_ready && mul_valid && !flush;
	// one booth digit per cycle while calculating
	assign step = (state == mul_pkg::CALC);
	// done pulse, suppressed when the op is being flushed
	assign out_valid = (state == mul_pkg::DONE) && !flush;

	// ****************************************
	// state machine
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mul_pkg::IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				mul_pkg::IDLE: begin
					if (load) begin
						state <= mul_pkg::CALC;
						cnt   <= '0;
					end
				end
				mul_pkg::CALC: begin
					cnt <= cnt + 1'b1;
					// abort mid-iteration
					if (flush)
						state <= mul_pkg::IDLE;
					else if (cnt == last_step[`MUL_CNT_W-1:0])
						state <= mul_pkg::DONE;
				end
				mul_pkg::DONE: begin
					// single cycle, flushed or not
					state <= mul_pkg::IDLE;
				end
				default: begin
					state <= mul_pkg::IDLE;
				end
			endcase
		end
	end

	// ****************************************
	// checks
	// ****************************************

	// done is a pulse, never a level
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		out_valid |=> !out_valid);

	// iteration count stays within the booth digit range
	a_cnt_range: assert property (@(posedge clk) disable iff (rst)
		cnt <= `MUL_STEPS);

	// accumulator never sees a load and a step on one edge
	a_load_step: assert property (@(posedge clk) disable iff (rst)
		!(load && step));

endmodule

/* hw/mul_operand_prep.sv */
`include "mul_cfg.svh"

module mul_operand_prep (
	input  mul_pkg::mul_req_t req,
	output mul_pkg::mul_ext_t ext
);

	localparam int half_w = `MUL_XLEN / 2;

	logic cand_signed;
	logic plier_signed;
	logic [`MUL_XLEN-1:0] cand_w;
	logic [`MUL_XLEN-1:0] plier_w;
	logic cand_top;
	logic plier_top;

	// sign_mode bit 1 for the multiplicand, bit 0 for the multiplier
	assign cand_signed  = req.sign_mode[1];
	assign plier_signed = req.sign_mode[0];

	// ****************************************
	// word mode selection
	// ****************************************

	// mulw uses only the low word of each operand
	always_comb begin
		cand_w  = req.multiplicand;
		plier_w = req.multiplier;
		if (req.mulw) begin
			cand_w = {{half_w{cand_signed & req.multiplicand[half_w-1]}},
				req.multiplicand[half_w-1:0]};
			plier_w = {{half_w{plier_signed & req.multiplier[half_w-1]}},
				req.multiplier[half_w-1:0]};
		end
	end

	// ****************************************
	// extension to the booth width
	// ****************************************

	// unsigned values get zeros on top, so the top digit stays positive
	assign cand_top  = cand_signed & cand_w[`MUL_XLEN-1];
	assign plier_top = plier_signed & plier_w[`MUL_XLEN-1];

	assign ext.multiplicand = {{2{cand_top}}, cand_w};
	assign ext.multiplier   = {{2{plier_top}}, plier_w};
	// carried along for result formatting
	assign ext.mulw         = req.mulw;

endmodule

/* hw/mul_pkg.sv */
`include "mul_cfg.svh"

package mul_pkg;

	// ****************************************
	// enums
	// ****************************************

	// control states of the multiply sequencer
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		CALC = 2'd1,
		DONE = 2'd2
	} mul_state_e;

	// radix-4 booth selection for one partial product
	typedef enum logic [2:0] {
		ZERO = 3'd0,
		ADD1 = 3'd1,
		ADD2 = 3'd2,
		SUB1 = 3'd3,
		SUB2 = 3'd4
	} booth_op_e;

	// ****************************************
	// structs
	// ****************************************

	// request as seen at the execute stage
	// sign_mode[1] multiplicand signed, sign_mode[0] multiplier signed
	typedef struct packed {
		logic                 mulw;
		logic [1:0]           sign_mode;
		logic [`MUL_XLEN-1:0] multiplicand;
		logic [`MUL_XLEN-1:0] multiplier;
	} mul_req_t;

	// operands after word selection and 66-bit extension
	typedef struct packed {
		logic [`MUL_EXT_W-1:0] multiplicand;
		logic [`MUL_EXT_W-1:0] multiplier;
		logic                  mulw;
	} mul_ext_t;

	// full 128-bit product split in two halves
	typedef struct packed {
		logic [`MUL_XLEN-1:0] result_hi;
		logic [`MUL_XLEN-1:0] result_lo;
	} mul_rsp_t;

endpackage

/* hw/mul_unit_top.sv */
`include "mul_cfg.svh"

module mul_unit_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              mul_valid,
	input  logic              flush,
	input  mul_pkg::mul_req_t req,
	output logic              mul_ready,
	output logic              out_valid,
	output mul_pkg::mul_rsp_t rsp
);

	// ****************************************
	// internal nets
	// ****************************************

	// sequencer strobes
	logic load;
	logic step;

	// prepared operands
	mul_pkg::mul_ext_t ext;

	// booth loop between accumulator and encoder
	logic [2:0]            digit;
	logic [`MUL_EXT_W-1:0] multiplicand;
	logic [`MUL_EXT_W+1:0] pp;

	// ****************************************
	// control
	// ****************************************

	mul_ctrl ctrl_i (
		.clk       (clk),
		.rst       (rst),
		.mul_valid (mul_valid),
		.flush     (flush),
		.mul_ready (mul_ready),
		.load      (load),
		.step      (step),
		.out_valid (out_valid)
	);

	// ****************************************
	// datapath
	// ****************************************

	mul_operand_prep prep_i (
		.req (req),
		.ext (ext)
	);

	// one partial product per step
	booth_encoder booth_i (
		.digit        (digit),
		.multiplicand (multiplicand),
		.pp           (pp)
	);

	mul_accumulator acc_i (
		.clk          (clk),
		.rst          (rst),
		.load         (load),
		.step         (step),
		.ext          (ext),
		.pp           (pp),
		.digit        (digit),
		.multiplicand (multiplicand),
		.rsp          (rsp)
	);

endmodule

/* include/mul_cfg.svh */
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// operand width of the integer datapath
`define MUL_XLEN 64

// two extra bits so an unsigned operand recodes correctly
`define MUL_EXT_W (`MUL_XLEN + 2)

// radix-4 retires two multiplier bits per step
`define MUL_STEPS (`MUL_EXT_W / 2)

// counter holds 0 .. MUL_STEPS
`define MUL_CNT_W 6

`endif

/* mul_unit.f */
+incdir+include
hw/mul_pkg.sv
hw/mul_ctrl.sv
hw/mul_operand_prep.sv
hw/booth_encoder.sv
hw/mul_accumulator.sv
hw/mul_unit_top.sv
sim/mul_unit_checker.sv
sim/mul_unit_tb.sv

/* sim/mul_unit_checker.sv */
`include "mul_cfg.svh"

module mul_unit_checker (
	input  logic              clk,
	input  logic              rst,
	input  logic              mul_valid,
	input  logic              flush,
	input  mul_pkg::mul_req_t req,
	input  logic              mul_ready,
	input  logic              out_valid,
	input  mul_pkg::mul_rsp_t rsp,
	output int                n_pass,
	output int                n_fail,
	output int                n_flushed
);

	localparam int xlen = `MUL_XLEN;
	localparam int half = `MUL_XLEN / 2;
	// 33 calc edges, then the done cycle
	localparam int latency = `MUL_STEPS + 1;

	mul_pkg::mul_req_t held;
	mul_pkg::mul_rsp_t exp_rsp;
	logic pending;
	logic ok;
	int edges;
	int t_acc;
	int test_id;

	// ****************************************
	// reference model
	// ****************************************

	// plain 128-bit multiply of the extended operands
	function automatic mul_pkg::mul_rsp_t expected_rsp(input mul_pkg::mul_req_t r);
		logic [2*xlen-1:0] a;
		logic [2*xlen-1:0] b;
		logic [2*xlen-1:0] p;
		mul_pkg::mul_rsp_t res;
		if (r.mulw) begin
			a = {{(2*xlen-half){r.sign_mode[1] & r.multiplicand[half-1]}},
				r.multiplicand[half-1:0]};
			b = {{(2*xlen-half){r.sign_mode[0] & r.multiplier[half-1]}},
				r.multiplier[half-1:0]};
		end else begin
			a = {{xlen{r.sign_mode[1] & r.multiplicand[xlen-1]}}, r.multiplicand};
			b = {{xlen{r.sign_mode[0] & r.multiplier[xlen-1]}}, r.multiplier};
		end
		p = a * b;
		res.result_hi = p[2*xlen-1:xlen];
		res.result_lo = p[xlen-1:0];
		// word result: low word, sign copied through both halves
		if (r.mulw) begin
			res.result_lo = {{half{p[half-1]}}, p[half-1:0]};
			res.result_hi = {xlen{p[half-1]}};
		end
		return res;
	endfunction

	// ****************************************
	// compare process
	// ****************************************

	always @(posedge clk) begin
		if (rst) begin
			pending = 1'b0;
			edges = 0;
			test_id = 0;
			n_pass = 0;
			n_fail = 0;
			n_flushed = 0;
		end else begin
			edges = edges + 1;
			// ready must stay low until the done pulse
			if (pending && (mul_ready || edges - t_acc > latency)) begin
				$display("test %0d failed: no done pulse within %0d edges", test_id, latency);
				n_fail++;
				pending = 1'b0;
			end else if (pending && flush) begin
				$display("test %0d flushed", test_id);
				n_flushed++;
				pending = 1'b0;
			end else if (out_valid && !pending) begin
				$display("out_valid at %0t with no operation in flight", $time);
				n_fail++;
			end else if (out_valid) begin
				exp_rsp = expected_rsp(held);
				ok = (edges - t_acc == latency);
				if (!ok)
					$display("done pulse %0d edges after accept", edges - t_acc);
				if (rsp.result_hi !== exp_rsp.result_hi) begin
					$display("FAILED at %0t: rsp.result_hi = %h, expected %h",
						$time, rsp.result_hi, exp_rsp.result_hi);
					ok = 1'b0;
				end
				if (rsp.result_lo !== exp_rsp.result_lo) begin
					$display("FAILED at %0t: rsp.result_lo = %h, expected %h",
						$time, rsp.result_lo, exp_rsp.result_lo);
					ok = 1'b0;
				end
				if (ok)
					n_pass++;
				else
					n_fail++;
				$display("test %0d %s: sign_mode %b mulw %b", test_id,
					ok ? "passed" : "failed", held.sign_mode, held.mulw);
				pending = 1'b0;
			end
			// accept edge latches the request for later
			if (mul_valid && mul_ready && !flush) begin
				held = req;
				t_acc = edges;
				pending = 1'b1;
				test_id++;
			end
		end
	end

endmodule

/* sim/mul_unit_tb.sv */
`include "mul_cfg.svh"

module mul_unit_tb;

	// cycles any single wait may take
	localparam int wait_limit = 3 * `MUL_STEPS;

	logic clk;
	logic rst;
	logic mul_valid;
	logic flush;
	mul_pkg::mul_req_t req;
	logic mul_ready;
	logic out_valid;
	mul_pkg::mul_rsp_t rsp;
	int n_pass;
	int n_fail;
	int n_flushed;
	int n_expected;
	int n_flush_sent;
	int tb_errs;
	int k;
	logic [31:0] rng;
	// zero, all ones, most negative, one
	logic [63:0] corners [4] = '{64'd0, {64{1'b1}}, 64'h8000_0000_0000_0000, 64'd1};

	mul_unit_top dut_i (.*);
	mul_unit_checker chk_i (.*);

	// ****************************************
	// clock and random source
	// ****************************************

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// two generator steps per 64-bit operand
	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		rng = xorshift32(rng);
		hi = rng;
		rng = xorshift32(rng);
		return {hi, rng};
	endfunction

	// ****************************************
	// request and done tasks
	// ****************************************

	// hold mul_valid until an edge finds the unit idle
	task automatic issue(input mul_pkg::mul_req_t r);
		int n;
		n = 0;
		req <= r;
		mul_valid <= 1'b1;
		do begin
			@(posedge clk);
			n++;
		end while (!mul_ready && n < wait_limit);
		mul_valid <= 1'b0;
		if (!mul_ready) begin
			$display("timeout: request not accepted within %0d cycles", wait_limit);
			tb_errs++;
		end else if (n != 1) begin
			// unit is idle here, also right after a done pulse
			$display("request accepted %0d edges late", n - 1);
			tb_errs++;
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!out_valid && n < wait_limit);
		if (!out_valid) begin
			$display("timeout: no out_valid within %0d cycles", wait_limit);
			tb_errs++;
		end
	endtask

	task automatic run_op(input logic w, input logic [1:0] mode, input logic [63:0] a,
		input logic [63:0] b);
		issue('{w, mode, a, b});
		n_expected++;
		wait_done();
	endtask

	// ****************************************
	// test sequence
	// ****************************************

	initial begin
		rst = 1'b1;
		mul_valid = 1'b0;
		flush = 1'b0;
		req = '0;
		rng = 32'hef5c_50af;
		n_expected = 0;
		n_flush_sent = 0;
		tb_errs = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		// idle outputs before any request
		if (mul_ready !== 1'b1) begin
			$display("FAILED at %0t: mul_ready = %b, expected 1", $time, mul_ready);
			tb_errs++;
		end
		if (out_valid !== 1'b0) begin
			$display("FAILED at %0t: out_valid = %b, expected 0", $time, out_valid);
			tb_errs++;
		end
		if (mul_ready === 1'b1 && out_valid === 1'b0)
			$display("reset check passed");
		else
			$display("reset check failed");
		// corners, full and word mode, all back to back
		for (int w = 0; w < 2; w++)
			for (int m = 0; m < 4; m++)
				foreach (corners[i])
					foreach (corners[j])
						run_op(w[0], m[1:0], corners[i], corners[j]);
		// random operands in every mode
		for (int i = 0; i < 8; i++)
			for (int w = 0; w < 2; w++)
				for (int m = 0; m < 4; m++)
					run_op(w[0], m[1:0], rand64(), rand64());
		// start pulse mid calc, new req must not leak in
		issue('{1'b0, 2'b11, rand64(), rand64()});
		n_expected++;
		repeat (10) @(posedge clk);
		mul_valid <= 1'b1;
		req <= '{1'b1, 2'b00, rand64(), rand64()};
		@(posedge clk);
		mul_valid <= 1'b0;
		wait_done();
		// flush lands on calc edge 1 .. 33
		for (int i = 0; i < 4; i++) begin
			issue('{1'b0, 2'b10, rand64(), rand64()});
			k = int'(rand64() % 64'd33);
			repeat (k) @(posedge clk);
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
			n_flush_sent++;
			// quiet span where a stray done pulse would show
			repeat (2 * `MUL_STEPS) @(posedge clk);
			run_op(1'b0, 2'b01, rand64(), rand64());
		end
		@(negedge clk);
		if (n_pass + n_fail != n_expected || n_flushed != n_flush_sent) begin
			$display("checker saw %0d results and %0d flushes, expected %0d and %0d",
				n_pass + n_fail, n_flushed, n_expected, n_flush_sent);
			tb_errs++;
		end
		$display("passed %0d, failed %0d, flushed %0d, testbench errors %0d",
			n_pass, n_fail, n_flushed, tb_errs);
		if (tb_errs == 0 && n_fail == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
